/* src/rv_m_pkg.sv */
// isa widths, register index type and m-extension funct3 codes.
package rv_m_pkg;

	// integer register width, fixed by rv64.
	localparam int xlen = 64;

	typedef logic [xlen-1:0]   xword_t; // full operand or result.
	typedef logic [xlen/2-1:0] half_t;  // low half used by word ops.
	typedef logic [4:0]        reg_idx_t; // destination register index.

	// funct3 field of the m extension, opcode op / op-32.
	typedef enum logic [2:0] {
		mul    = 3'b000, // low product.
		mulh   = 3'b001, // high, signed x signed.
		mulhsu = 3'b010, // high, signed x unsigned.
		mulhu  = 3'b011, // high, unsigned x unsigned.
		div    = 3'b100,
		divu   = 3'b101,
		rem    = 3'b110,
		remu   = 3'b111
	} m_funct3_e;

	// funct3[2] splits multiply from divide.
	// for divide, bit 0 means unsigned and bit 1 means remainder.
	// word ops reuse the same codes with the word flag set.

endpackage

/* src/mdu_pkg.sv */
// issue, control and result structs, divider states and iteration counts of the mdu.
package mdu_pkg;

	// one op from the issue stage, operands already read.
	typedef struct packed {
		rv_m_pkg::m_funct3_e funct3;
		logic                word;  // op-32 form.
		rv_m_pkg::xword_t    src1;
		rv_m_pkg::xword_t    src2;
		rv_m_pkg::reg_idx_t  rd;
	} mdu_issue_t; // 137 bits.

	// multiplier control, derived from funct3 in decode.
	typedef struct packed {
		logic src1_signed; // sign extend rs1.
		logic src2_signed; // sign extend rs2.
		logic high;        // take product bits 127:64.
		logic word;        // mulw, low 32 bits sign extended.
	} mul_ctrl_t;

	// divider control.
	typedef struct packed {
		logic sgn;  // div / rem, as opposed to divu / remu.
		logic rem;  // return remainder instead of quotient.
		logic word; // 32 bit operands and result.
	} div_ctrl_t;

	// writeback payload of either unit.
	typedef struct packed {
		rv_m_pkg::reg_idx_t rd;
		rv_m_pkg::xword_t   data;
	} mdu_result_t; // 69 bits.

	// divider fsm.
	typedef enum logic [1:0] {
		idle = 2'd0,
		run  = 2'd1, // shift-subtract steps, then one fixup cycle.
		done = 2'd2  // result held, request raised.
	} div_state_e;

	// one quotient bit per step.
	localparam int div_iter_full = 64;
	localparam int div_iter_word = 32;

	typedef logic [6:0] div_cnt_t; // step counter, must reach div_iter_full.

endpackage

/* src/mdu_decode.sv */
// decode of funct3 and the word flag into unit starts, control structs and issue_ready.
`timescale 1ns/1ps

module mdu_decode (
	input  logic                issue_valid,
	input  mdu_pkg::mdu_issue_t issue,
	output logic                issue_ready,
	input  logic                mul_ready,
	input  logic                div_ready,
	output logic                mul_start,
	output logic                div_start,
	output mdu_pkg::mul_ctrl_t  mul_ctrl,
	output mdu_pkg::div_ctrl_t  div_ctrl
);

	logic is_div; // funct3[2] set.

	assign is_div = issue.funct3[2];

	// ready follows whichever unit the op targets.
	assign issue_ready = is_div ? div_ready : mul_ready;

	assign mul_start = issue_valid & ~is_div & mul_ready;
	assign div_start = issue_valid &  is_div & div_ready;

	always_comb begin
		// low product is sign agnostic so mul just reuses the signed path.
		mul_ctrl.src1_signed = (issue.funct3 == rv_m_pkg::mul) |
			(issue.funct3 == rv_m_pkg::mulh) | (issue.funct3 == rv_m_pkg::mulhsu);
		mul_ctrl.src2_signed = (issue.funct3 == rv_m_pkg::mul) |
			(issue.funct3 == rv_m_pkg::mulh);
		mul_ctrl.high = (issue.funct3 != rv_m_pkg::mul); // mulh, mulhsu, mulhu.
		mul_ctrl.word = issue.word; // only mulw exists.
	end

	always_comb begin
		div_ctrl.sgn  = ~issue.funct3[0]; // div, rem.
		div_ctrl.rem  =  issue.funct3[1]; // rem, remu.
		div_ctrl.word =  issue.word;
	end

endmodule

/* src/mul_unit.sv */
// registered 64x64 multiplier with high, low and word select.
`timescale 1ns/1ps

module mul_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  mdu_pkg::mdu_issue_t  issue,
	input  mdu_pkg::mul_ctrl_t   ctrl,
	output logic                 ready,
	output logic                 req,
	input  logic                 grant,
	output mdu_pkg::mdu_result_t result
);

	logic signed [rv_m_pkg::xlen:0]     op_a;   // 65 bit with per-operand extension.
	logic signed [rv_m_pkg::xlen:0]     op_b;
	logic signed [2*rv_m_pkg::xlen-1:0] prod;   // product modulo 2^128.
	rv_m_pkg::half_t                    lo_word;
	rv_m_pkg::xword_t                   res_data;
	logic                               full;   // result register holds an op.

	// extend by the sign bit only where that operand is signed.
	assign op_a = {ctrl.src1_signed & issue.src1[rv_m_pkg::xlen-1], issue.src1};
	assign op_b = {ctrl.src2_signed & issue.src2[rv_m_pkg::xlen-1], issue.src2};
	assign prod = op_a * op_b;

	assign lo_word = prod[rv_m_pkg::xlen/2-1:0]; // mulw.

	always_comb begin
		if (ctrl.word) begin
			res_data = {{(rv_m_pkg::xlen/2){lo_word[rv_m_pkg::xlen/2-1]}}, lo_word};
		end else if (ctrl.high) begin
			res_data = prod[2*rv_m_pkg::xlen-1:rv_m_pkg::xlen];
		end else begin
			res_data = prod[rv_m_pkg::xlen-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (start) begin
			full <= 1'b1; // new op overrides a grant in the same cycle.
		end else if (grant) begin
			full <= 1'b0;
		end
	end

	// payload is only meaningful while full.
	always_ff @(posedge clk) begin
		if (start) begin
			result.rd   <= issue.rd;
			result.data <= res_data;
		end
	end

	assign ready = ~full | grant; // slot frees in the grant cycle.
	assign req   = full;

	// a held result is never overwritten before its writeback.
	a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
		start |-> (!full || grant));

endmodule

/* src/div_unit.sv */
// iterative restoring divider with riscv zero and overflow rules.
`timescale 1ns/1ps

module div_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  mdu_pkg::mdu_issue_t  issue,
	input  mdu_pkg::div_ctrl_t   ctrl,
	output logic                 ready,
	output logic                 req,
	input  logic                 grant,
	output mdu_pkg::mdu_result_t result
);

	mdu_pkg::div_state_e      state;
	mdu_pkg::div_cnt_t        count; // steps done so far.
	mdu_pkg::div_cnt_t        last;  // step count of the current op.
	mdu_pkg::div_ctrl_t       ctrl_r;
	rv_m_pkg::half_t          a_lo, b_lo;
	rv_m_pkg::xword_t         a_ext, b_ext; // operands after word extension.
	rv_m_pkg::xword_t         abs_a, abs_b;
	logic                     neg_a, neg_b;
	logic                     zero_in, ovf_in;
	rv_m_pkg::xword_t         quo_r;  // dividend bits shift out and quotient bits in.
	rv_m_pkg::xword_t         rem_r;  // partial remainder.
	rv_m_pkg::xword_t         dvsr_r; // |divisor|.
	rv_m_pkg::xword_t         dvnd_r; // extended dividend for the special cases.
	rv_m_pkg::reg_idx_t       rd_r;
	logic                     neg_q_r, neg_r_r, zero_r, ovf_r;
	logic [rv_m_pkg::xlen:0]   shifted; // remainder shifted left with the next dividend bit.
	logic [rv_m_pkg::xlen+1:0] trial;   // msb set means borrow.
	rv_m_pkg::xword_t         q_fix, r_fix, pick, fin;

	// word ops extend the low halves on entry as signed or unsigned.
	assign a_lo  = issue.src1[rv_m_pkg::xlen/2-1:0];
	assign b_lo  = issue.src2[rv_m_pkg::xlen/2-1:0];
	assign a_ext = ctrl.word ?
		{{(rv_m_pkg::xlen/2){ctrl.sgn & a_lo[rv_m_pkg::xlen/2-1]}}, a_lo} : issue.src1;
	assign b_ext = ctrl.word ?
		{{(rv_m_pkg::xlen/2){ctrl.sgn & b_lo[rv_m_pkg::xlen/2-1]}}, b_lo} : issue.src2;

	assign neg_a = ctrl.sgn & a_ext[rv_m_pkg::xlen-1];
	assign neg_b = ctrl.sgn & b_ext[rv_m_pkg::xlen-1];
	assign abs_a = neg_a ? -a_ext : a_ext;
	assign abs_b = neg_b ? -b_ext : b_ext;

	assign zero_in = (b_ext == '0);
	// most negative dividend over -1 in the op's width.
	assign ovf_in = ctrl.sgn & (b_ext == '1) & (ctrl.word ?
		(a_ext == {{(rv_m_pkg::xlen/2+1){1'b1}}, {(rv_m_pkg::xlen/2-1){1'b0}}}) :
		(a_ext == {1'b1, {(rv_m_pkg::xlen-1){1'b0}}}));

	// one restoring step.
	assign shifted = {rem_r, quo_r[rv_m_pkg::xlen-1]};
	assign trial   = {1'b0, shifted} - {2'b00, dvsr_r};

	assign last = ctrl_r.word ? mdu_pkg::div_cnt_t'(mdu_pkg::div_iter_word) :
		mdu_pkg::div_cnt_t'(mdu_pkg::div_iter_full);

	// fixup applies signs, then the special cases, then word extension.
	assign q_fix = neg_q_r ? -quo_r : quo_r;
	assign r_fix = neg_r_r ? -rem_r : rem_r; // remainder follows the dividend.

	always_comb begin
		if (zero_r) begin
			pick = ctrl_r.rem ? dvnd_r : '1;
		end else if (ovf_r) begin
			pick = ctrl_r.rem ? '0 : dvnd_r;
		end else begin
			pick = ctrl_r.rem ? r_fix : q_fix;
		end
		fin = ctrl_r.word ? {{(rv_m_pkg::xlen/2){pick[rv_m_pkg::xlen/2-1]}},
			pick[rv_m_pkg::xlen/2-1:0]} : pick;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mdu_pkg::idle;
		end else begin
			case (state)
				mdu_pkg::idle: if (start) state <= mdu_pkg::run;
				mdu_pkg::run:  if (count == last) state <= mdu_pkg::done; // fixup edge.
				mdu_pkg::done: if (grant) state <= mdu_pkg::idle;
				default:       state <= mdu_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			// word dividend sits in the top half so 32 steps consume it.
			quo_r   <= ctrl.word ? {abs_a[rv_m_pkg::xlen/2-1:0], {(rv_m_pkg::xlen/2){1'b0}}}
				: abs_a;
			rem_r   <= '0;
			dvsr_r  <= abs_b;
			dvnd_r  <= a_ext;
			rd_r    <= issue.rd;
			ctrl_r  <= ctrl;
			neg_q_r <= neg_a ^ neg_b;
			neg_r_r <= neg_a;
			zero_r  <= zero_in;
			ovf_r   <= ovf_in;
			count   <= '0;
		end else if (state == mdu_pkg::run) begin
			count <= count + 1'b1;
			if (count != last) begin
				rem_r <= trial[rv_m_pkg::xlen+1] ? shifted[rv_m_pkg::xlen-1:0] :
					trial[rv_m_pkg::xlen-1:0];
				quo_r <= {quo_r[rv_m_pkg::xlen-2:0], ~trial[rv_m_pkg::xlen+1]};
			end else begin
				result.rd   <= rd_r;
				result.data <= fin;
			end
		end
	end

	assign ready = (state == mdu_pkg::idle);
	assign req   = (state == mdu_pkg::done);

	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> state == mdu_pkg::idle);

endmodule

/* src/wb_arbiter.sv */
// fixed-priority grant of mul and div results onto a wishbone classic write.
`timescale 1ns/1ps

module wb_arbiter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 mul_req,
	input  mdu_pkg::mdu_result_t mul_result,
	input  logic                 div_req,
	input  mdu_pkg::mdu_result_t div_result,
	output logic                 mul_grant,
	output logic                 div_grant,
	output logic                 wb_cyc,
	output logic                 wb_stb,
	output logic                 wb_we,
	output rv_m_pkg::reg_idx_t   wb_adr,
	output rv_m_pkg::xword_t     wb_dat,
	input  logic                 wb_ack
);

	logic                 sel_div; // owner of the current bus cycle.
	mdu_pkg::mdu_result_t sel_result;

	// cycle opens one edge after a request on an idle bus and closes on ack.
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_cyc <= 1'b0;
		end else if (!wb_cyc) begin
			wb_cyc <= mul_req | div_req;
		end else if (wb_ack) begin
			wb_cyc <= 1'b0;
		end
	end

	// latched while idle and the divider wins ties.
	always_ff @(posedge clk) begin
		if (!wb_cyc) begin
			sel_div <= div_req;
		end
	end

	// units hold their result until granted so the bus stays stable.
	assign sel_result = sel_div ? div_result : mul_result;

	assign wb_stb = wb_cyc; // single transfer per cycle.
	assign wb_we  = 1'b1;   // writeback only.
	assign wb_adr = sel_result.rd;
	assign wb_dat = sel_result.data;

	// grant pulses in the ack cycle.
	assign mul_grant = wb_cyc & wb_ack & ~sel_div;
	assign div_grant = wb_cyc & wb_ack &  sel_div;

	// held by the owning unit until ack.
	a_stable: assert property (@(posedge clk) disable iff (reset)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat)));

endmodule

/* src/mdu_top.sv */
// top level with decode, multiplier, divider and writeback arbiter of the m extension.
`timescale 1ns/1ps

module mdu_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue_valid,
	input  mdu_pkg::mdu_issue_t issue,
	output logic                issue_ready,
	output logic                wb_cyc,
	output logic                wb_stb,
	output logic                wb_we,
	output rv_m_pkg::reg_idx_t  wb_adr,
	output rv_m_pkg::xword_t    wb_dat,
	input  logic                wb_ack
);

	logic                 mul_ready, div_ready;
	logic                 mul_start, div_start;
	mdu_pkg::mul_ctrl_t   mul_ctrl;
	mdu_pkg::div_ctrl_t   div_ctrl;
	logic                 mul_req, div_req;
	logic                 mul_grant, div_grant;
	mdu_pkg::mdu_result_t mul_result, div_result;

	mdu_decode u_mdu_decode (
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_ready (issue_ready),
		.mul_ready   (mul_ready),
		.div_ready   (div_ready),
		.mul_start   (mul_start),
		.div_start   (div_start),
		.mul_ctrl    (mul_ctrl),
		.div_ctrl    (div_ctrl)
	);

	mul_unit u_mul_unit (
		.clk    (clk),
		.reset  (reset),
		.start  (mul_start),
		.issue  (issue),
		.ctrl   (mul_ctrl),
		.ready  (mul_ready),
		.req    (mul_req),
		.grant  (mul_grant),
		.result (mul_result)
	);

	div_unit u_div_unit (
		.clk    (clk),
		.reset  (reset),
		.start  (div_start),
		.issue  (issue),
		.ctrl   (div_ctrl),
		.ready  (div_ready),
		.req    (div_req),
		.grant  (div_grant),
		.result (div_result)
	);

	// single writeback port shared by both units.
	wb_arbiter u_wb_arbiter (
		.clk        (clk),
		.reset      (reset),
		.mul_req    (mul_req),
		.mul_result (mul_result),
		.div_req    (div_req),
		.div_result (div_result),
		.mul_grant  (mul_grant),
		.div_grant  (div_grant),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat     (wb_dat),
		.wb_ack     (wb_ack)
	);

endmodule

/* testbench/mdu_checker.sv */
// reference model of the m ops, expected results by rd, reset, bus and writeback checks.
`timescale 1ns/1ps

module mdu_checker (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue_valid,
	input  mdu_pkg::mdu_issue_t issue,
	input  logic                issue_ready,
	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  rv_m_pkg::reg_idx_t  wb_adr,
	input  rv_m_pkg::xword_t    wb_dat,
	input  logic                wb_ack,
	output int                  errors,
	output int                  checks,
	output int                  outstanding
);

	rv_m_pkg::xword_t   expected [32]; // model result per rd.
	logic [31:0]        pending;       // result not yet written back.
	logic               first_cycle;   // first edge after reset release.
	logic               held;          // last edge saw stb without ack.
	rv_m_pkg::reg_idx_t last_adr;
	rv_m_pkg::xword_t   last_dat;

	function automatic rv_m_pkg::xword_t sext_word(input rv_m_pkg::half_t w);
		return {{32{w[31]}}, w};
	endfunction

	// full 128 bit product, operands extended as the op defines.
	function automatic rv_m_pkg::xword_t mul_model(input mdu_pkg::mdu_issue_t op);
		logic [127:0] a;
		logic [127:0] b;
		logic [127:0] p;
		a = {{64{op.src1[63] & (op.funct3 != rv_m_pkg::mulhu)}}, op.src1};
		b = {{64{op.src2[63] & (op.funct3 == rv_m_pkg::mulh)}}, op.src2};
		p = a * b;
		if (op.word) return sext_word(p[31:0]); // mulw.
		if (op.funct3 == rv_m_pkg::mul) return p[63:0];
		return p[127:64];
	endfunction

	// quotient truncates toward zero, remainder keeps the dividend sign.
	function automatic rv_m_pkg::xword_t div_model(input mdu_pkg::mdu_issue_t op);
		logic signed [63:0] a;
		logic signed [63:0] b;
		logic signed [63:0] q;
		logic signed [63:0] r;
		logic [63:0]        res;
		logic               sgn;
		sgn = ~op.funct3[0];
		if (op.word) begin
			a = sgn ? sext_word(op.src1[31:0]) : {32'b0, op.src1[31:0]};
			b = sgn ? sext_word(op.src2[31:0]) : {32'b0, op.src2[31:0]};
		end else begin
			a = op.src1;
			b = op.src2;
		end
		if (b == 0) begin
			q = '1; // all ones.
			r = a;
		end else if (sgn && b == -1) begin
			q = -a; // wraps to the dividend on overflow.
			r = '0;
		end else if (sgn) begin
			q = a / b;
			r = a % b;
		end else begin
			q = $unsigned(a) / $unsigned(b);
			r = $unsigned(a) % $unsigned(b);
		end
		res = op.funct3[1] ? r : q;
		return op.word ? sext_word(res[31:0]) : res;
	endfunction

	function automatic rv_m_pkg::xword_t model_result(input mdu_pkg::mdu_issue_t op);
		return op.funct3[2] ? div_model(op) : mul_model(op);
	endfunction

	task automatic compare_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			pending     = '0;
			errors      = 0;
			checks      = 0;
			outstanding = 0;
			first_cycle = 1'b1;
			held        = 1'b0;
		end else begin
			if (first_cycle) begin // idle state out of reset.
				compare_value("issue_ready", 64'd1, issue_ready);
				compare_value("wb_cyc", 64'd0, wb_cyc);
				compare_value("wb_stb", 64'd0, wb_stb);
				first_cycle = 1'b0;
			end
			if (wb_stb && !wb_cyc) begin
				errors++;
				$display("wb_stb is high outside a bus cycle");
			end
			if (wb_cyc) begin
				compare_value("wb_we", 64'd1, wb_we); // write only.
				if (held) begin
					compare_value("wb_adr", last_adr, wb_adr);
					compare_value("wb_dat", last_dat, wb_dat);
				end
			end else if (held) begin
				errors++;
				$display("bus cycle to x%0d ended without an ack", last_adr);
			end
			held     = wb_cyc && wb_stb && !wb_ack;
			last_adr = wb_adr;
			last_dat = wb_dat;

			if (wb_cyc && wb_stb && wb_ack) begin
				if (!pending[wb_adr]) begin
					errors++;
					$display("write to x%0d acked with no result pending for it", wb_adr);
				end else begin
					compare_value($sformatf("wb_dat x%0d", wb_adr), expected[wb_adr], wb_dat);
					pending[wb_adr] = 1'b0;
					outstanding--;
				end
			end

			if (issue_valid && issue_ready) begin
				if (pending[issue.rd]) begin
					errors++;
					$display("op issued to x%0d while its previous result is pending", issue.rd);
				end else begin
					outstanding++;
				end
				expected[issue.rd] = model_result(issue);
				pending[issue.rd]  = 1'b1;
			end
		end
	end

endmodule

/* testbench/tb_mdu.sv */
// top testbench with clock, reset, random op issue, wishbone slave with random ack delay and timeout.
`timescale 1ns/1ps

module tb_mdu;

	localparam int n_ops       = 400;
	localparam int cycle_limit = n_ops * 80; // longest divide plus bus wait per op.

	logic                clk;
	logic                reset;
	logic                issue_valid;
	mdu_pkg::mdu_issue_t issue;
	logic                issue_ready;
	logic                wb_cyc, wb_stb, wb_we, wb_ack;
	rv_m_pkg::reg_idx_t  wb_adr;
	rv_m_pkg::xword_t    wb_dat;
	int                  errors, checks, outstanding;
	integer              seed;
	int                  issued;
	int                  ack_wait;   // wait cycles left or -1 when no delay is drawn.
	int                  cycles = 0;
	logic                took;       // transfer on the last rising edge.

	mdu_top u_mdu_top (
		.clk         (clk),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_ready (issue_ready),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat      (wb_dat),
		.wb_ack      (wb_ack)
	);

	mdu_checker u_checker (
		.clk         (clk),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_ready (issue_ready),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat      (wb_dat),
		.wb_ack      (wb_ack),
		.errors      (errors),
		.checks      (checks),
		.outstanding (outstanding)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	always @(posedge clk) took <= issue_valid & issue_ready;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles: %0d of %0d ops issued, %0d results pending",
				cycles, issued, n_ops, outstanding);
			$display("%0d errors in %0d checks", errors, checks);
			$display("tests failed");
			$finish;
		end
	end

	// random op with a special divisor under the most negative dividend in about a quarter.
	task automatic make_op(input rv_m_pkg::reg_idx_t rd);
		logic [2:0]  f;
		logic [31:0] hi;
		logic [63:0] div64;
		logic [31:0] div32;
		f            = 3'($random(seed));
		issue.funct3 = rv_m_pkg::m_funct3_e'(f);
		issue.word   = 1'($random(seed)) & (f[2] | (f == 3'b000)); // no word form of mulh*.
		issue.src1   = {$random(seed), $random(seed)};
		issue.src2   = {$random(seed), $random(seed)};
		issue.rd     = rd;
		hi           = $random(seed);
		if ({$random(seed)} % 4 == 0) begin
			case ({$random(seed)} % 3)
				0: begin
					div64 = '0;
					div32 = '0;
				end
				1: begin
					div64 = '1;
					div32 = '1;
				end
				default: begin
					div64 = {1'b1, 63'b0};
					div32 = {1'b1, 31'b0};
				end
			endcase
			if (issue.word) begin
				issue.src1 = {hi, 32'h8000_0000}; // upper half must be ignored.
				issue.src2 = {~hi, div32};
			end else begin
				issue.src1 = {1'b1, 63'b0};
				issue.src2 = div64;
			end
		end
	endtask

	// wishbone slave acks each bus cycle after 0 to 3 wait cycles.
	task automatic drive_ack();
		if (wb_ack) begin
			wb_ack = 1'b0; // cycle closed on the last edge.
		end else if (wb_cyc) begin
			if (ack_wait < 0) ack_wait = {$random(seed)} % 4;
			if (ack_wait == 0) wb_ack = 1'b1;
			ack_wait = ack_wait - 1;
		end
	endtask

	initial begin
		seed        = 32'hc93d;
		reset       = 1'b1;
		issue_valid = 1'b0;
		issue       = '0;
		wb_ack      = 1'b0;
		ack_wait    = -1;
		issued      = 0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		while (issued < n_ops || outstanding != 0) begin
			@(negedge clk);
			drive_ack();
			if (issue_valid && took) begin
				issued++;
				issue_valid = 1'b0;
			end
			if (!issue_valid && issued < n_ops) begin
				make_op(rv_m_pkg::reg_idx_t'(issued)); // rd wraps every 32 ops.
				issue_valid = 1'b1;
			end
		end
		repeat (20) begin // quiet tail where stray bus cycles still get acked.
			@(negedge clk);
			drive_ack();
		end
		$display("%0d errors in %0d checks over %0d ops", errors, checks, issued);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* flist.f */
src/rv_m_pkg.sv
src/mdu_pkg.sv
src/mdu_decode.sv
src/mul_unit.sv
src/div_unit.sv
src/wb_arbiter.sv
src/mdu_top.sv
testbench/mdu_checker.sv
testbench/tb_mdu.sv

/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_mdu
FLIST = flist.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)
